//--- hdl/mem_pkg.sv
package mem_pkg;

    // loads use funct3 as is, stores take the three codes loads leave free
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        SB  = 3'b011,                       // free funct3 slot
        LBU = 3'b100,
        LHU = 3'b101,
        SH  = 3'b110,                       // free funct3 slot
        SW  = 3'b111                        // free funct3 slot
    } lsu_op_e;

    // one state per byte moved, lanes named by mask bit
    typedef enum logic [3:0] {
        STABLE   = 4'd0,
        B_LANE0  = 4'd1,                    // mask 0001
        B_LANE1  = 4'd2,                    // mask 0010
        B_LANE2  = 4'd3,                    // mask 0100
        B_LANE3  = 4'd4,                    // mask 1000
        H_LOW_1  = 4'd5,                    // mask 0011, lane 1 first
        H_LOW_2  = 4'd6,
        H_HIGH_1 = 4'd7,                    // mask 1100, lane 3 first
        H_HIGH_2 = 4'd8,
        W_1      = 4'd9,                    // mask 1111, lane 3 down to lane 0
        W_2      = 4'd10,
        W_3      = 4'd11,
        W_4      = 4'd12,
        FINISH   = 4'd13
    } mif_state_e;

    localparam int LANES = 4;               // byte lanes per word

endpackage

//--- hdl/byte_ram.sv
`timescale 1ns/100ps

module byte_ram #(
    parameter  int DEPTH = 1024,            // bytes, power of two
    localparam int AW    = $clog2(DEPTH)
)
(
    input  logic          CLK,
    input  logic          en,
    input  logic          we,
    input  logic [AW-1:0] addr,
    input  logic [7:0]    wdata,
    output logic [7:0]    rdata
);

    logic [7:0] mem [DEPTH];

    always_ff @(posedge CLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];             // read-first on a write cycle
        end
    end

endmodule

//--- hdl/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit
    import mem_pkg::*;
(
    input  logic          CLK,
    input  logic          rst_n,
    input  logic          valid,
    input  lsu_op_e       op,
    input  logic [31:0]   addr,
    input  logic [31:0]   wdata,
    output logic          ready,
    output logic [31:0]   rdata,
    output logic          misaligned,
    output logic          req,
    output logic [3:0]    frame_mask,
    output logic [31:0]   word_addr,
    output logic          is_write,
    output logic [31:0]   store_lanes,
    input  logic [31:0]   load_lanes,
    input  logic          done
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        RESPOND
    } lsu_state_e;

    lsu_state_e  state;
    logic [1:0]  size;                      // 0 byte, 1 half, 2 word
    logic        is_signed;
    logic        align_err;
    logic [1:0]  offset;
    logic [1:0]  byte_lane;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] load_ext;

    always_comb begin
        size      = 2'd2;
        is_signed = 1'b0;
        is_write  = 1'b0;
        case (op)
            LB:  begin size = 2'd0; is_signed = 1'b1; end
            LH:  begin size = 2'd1; is_signed = 1'b1; end
            LW:  size = 2'd2;
            LBU: size = 2'd0;
            LHU: size = 2'd1;
            SB:  begin size = 2'd0; is_write = 1'b1; end
            SH:  begin size = 2'd1; is_write = 1'b1; end
            SW:  begin size = 2'd2; is_write = 1'b1; end
            default: size = 2'd2;
        endcase
    end

    assign offset    = addr[1:0];
    assign byte_lane = 2'(LANES - 1) - offset;  // offset 0 sits in the top lane
    assign word_addr = {addr[31:2], 2'b00};
    assign align_err = ((size == 2'd1) && offset[0]) || ((size == 2'd2) && (offset != 2'd0));

    // lane selection and store replication
    always_comb begin
        case (size)
            2'd0: begin
                frame_mask  = 4'b1000 >> offset;
                store_lanes = {LANES{wdata[7:0]}};
            end
            2'd1: begin
                frame_mask  = offset[1] ? 4'b0011 : 4'b1100;
                store_lanes = {2{wdata[15:0]}};
            end
            default: begin
                frame_mask  = 4'b1111;
                store_lanes = wdata;
            end
        endcase
    end

    assign sel_byte = load_lanes[8*byte_lane +: 8];
    assign sel_half = offset[1] ? load_lanes[15:0] : load_lanes[31:16];

    always_comb begin
        case (size)
            2'd0:    load_ext = {{24{is_signed & sel_byte[7]}}, sel_byte};
            2'd1:    load_ext = {{16{is_signed & sel_half[15]}}, sel_half};
            default: load_ext = load_lanes;
        endcase
    end

    assign req = (state == BUSY);           // dropped in RESPOND so the interface idles

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            ready      <= 1'b0;
            misaligned <= 1'b0;
        end else begin
            ready      <= 1'b0;             // single-cycle pulse
            misaligned <= 1'b0;
            case (state)
                IDLE: begin
                    if (valid && align_err) begin
                        ready      <= 1'b1;
                        misaligned <= 1'b1;
                        state      <= RESPOND;
                    end else if (valid) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (done) begin
                        ready <= 1'b1;
                        state <= RESPOND;
                    end
                end
                RESPOND: state <= IDLE;     // core still holds the old request here
                default: state <= IDLE;
            endcase
        end
    end

    // result payload
    always_ff @(posedge CLK) begin
        if (state == BUSY && done) begin
            rdata <= is_write ? 32'd0 : load_ext;
        end else if (state == IDLE && valid && align_err) begin
            rdata <= 32'd0;
        end
    end

endmodule

//--- hdl/memory_interface.sv
`timescale 1ns/100ps

module memory_interface
    import mem_pkg::*;
#(
    parameter  int DEPTH = 1024,
    localparam int AW    = $clog2(DEPTH)
)
(
    input  logic          CLK,
    input  logic          rst_n,
    input  logic          req,
    input  logic [3:0]    frame_mask,
    input  logic [31:0]   word_addr,
    input  logic          is_write,
    input  logic [31:0]   store_lanes,
    output logic [31:0]   load_lanes,
    output logic          done,
    output logic          ram_en,
    output logic          ram_we,
    output logic [AW-1:0] ram_addr,
    output logic [7:0]    ram_wdata,
    input  logic [7:0]    ram_rdata
);

    mif_state_e         state;
    mif_state_e         next_state;
    logic [1:0]         cur_lane;           // lane handled in this state
    logic               active;
    logic [1:0]         byte_off;
    logic               pend_q;             // a read was issued last cycle
    logic [1:0]         pend_lane_q;
    logic [8*LANES-1:0] lanes_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= STABLE;
        end else if (!req) begin
            state <= STABLE;                // request withdrawn
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = STABLE;
        cur_lane   = 2'd0;
        active     = 1'b1;
        case (state)
            STABLE: begin
                active = 1'b0;
                case (frame_mask)
                    4'b0001: next_state = B_LANE0;
                    4'b0010: next_state = B_LANE1;
                    4'b0100: next_state = B_LANE2;
                    4'b1000: next_state = B_LANE3;
                    4'b0011: next_state = H_LOW_1;
                    4'b1100: next_state = H_HIGH_1;
                    4'b1111: next_state = W_1;
                    default: next_state = STABLE;   // other masks are never issued
                endcase
            end
            B_LANE0:  begin cur_lane = 2'd0; next_state = FINISH; end
            B_LANE1:  begin cur_lane = 2'd1; next_state = FINISH; end
            B_LANE2:  begin cur_lane = 2'd2; next_state = FINISH; end
            B_LANE3:  begin cur_lane = 2'd3; next_state = FINISH; end
            H_LOW_1:  begin cur_lane = 2'd1; next_state = H_LOW_2; end
            H_LOW_2:  begin cur_lane = 2'd0; next_state = FINISH; end
            H_HIGH_1: begin cur_lane = 2'd3; next_state = H_HIGH_2; end
            H_HIGH_2: begin cur_lane = 2'd2; next_state = FINISH; end
            W_1:      begin cur_lane = 2'd3; next_state = W_2; end
            W_2:      begin cur_lane = 2'd2; next_state = W_3; end
            W_3:      begin cur_lane = 2'd1; next_state = W_4; end
            W_4:      begin cur_lane = 2'd0; next_state = FINISH; end
            FINISH: begin
                active     = 1'b0;
                next_state = STABLE;
            end
            default: active = 1'b0;
        endcase
    end

    // big-endian lanes, lane i lives at word_base + 3 - i
    assign byte_off  = 2'(LANES - 1) - cur_lane;
    assign ram_addr  = {word_addr[AW-1:2], byte_off};   // upper bits dropped, wraps in DEPTH
    assign ram_en    = active;
    assign ram_we    = active & is_write;
    assign ram_wdata = store_lanes[8*cur_lane +: 8];
    assign done      = (state == FINISH);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= active & ~is_write;
        end
    end

    always_ff @(posedge CLK) begin
        pend_lane_q <= cur_lane;
        if (pend_q) begin
            lanes_q[8*pend_lane_q +: 8] <= ram_rdata;   // byte from the previous state
        end
    end

    // last byte arrives during FINISH, so it is merged in without waiting a cycle
    always_comb begin
        load_lanes = lanes_q;
        if (pend_q) begin
            load_lanes[8*pend_lane_q +: 8] = ram_rdata;
        end
    end

endmodule

//--- hdl/data_memory_subsystem.sv
`timescale 1ns/100ps

module data_memory_subsystem
    import mem_pkg::*;
#(
    parameter  int DEPTH = 1024,
    localparam int AW    = $clog2(DEPTH)
)
(
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        valid,
    input  lsu_op_e     op,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        ready,
    output logic [31:0] rdata,
    output logic        misaligned
);

    logic          req;
    logic [3:0]    frame_mask;
    logic [31:0]   word_addr;
    logic          is_write;
    logic [31:0]   store_lanes;
    logic [31:0]   load_lanes;
    logic          done;
    logic          ram_en;
    logic          ram_we;
    logic [AW-1:0] ram_addr;
    logic [7:0]    ram_wdata;
    logic [7:0]    ram_rdata;

    load_store_unit load_store_unit_inst (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .valid       (valid),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .ready       (ready),
        .rdata       (rdata),
        .misaligned  (misaligned),
        .req         (req),
        .frame_mask  (frame_mask),
        .word_addr   (word_addr),
        .is_write    (is_write),
        .store_lanes (store_lanes),
        .load_lanes  (load_lanes),
        .done        (done)
    );

    memory_interface #(
        .DEPTH (DEPTH)
    ) memory_interface_inst (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .req         (req),
        .frame_mask  (frame_mask),
        .word_addr   (word_addr),
        .is_write    (is_write),
        .store_lanes (store_lanes),
        .load_lanes  (load_lanes),
        .done        (done),
        .ram_en      (ram_en),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata)
    );

    byte_ram #(
        .DEPTH (DEPTH)
    ) byte_ram_inst (
        .CLK   (CLK),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

//--- verification/tb_data_memory_subsystem.sv
`timescale 1ns/100ps

module tb_data_memory_subsystem
    import mem_pkg::*;
();

    localparam int DEPTH      = 1024;
    localparam int AW         = $clog2(DEPTH);
    localparam int WIN_BASE   = 32'h100;    // all traffic stays in this window
    localparam int WIN_WORDS  = 16;
    localparam int N_ROUND    = 20;
    localparam int N_MIX      = 250;
    localparam int N_REQ      = WIN_WORDS + 2 * N_ROUND + 5 + 26 + 4 + 16 + N_MIX;
    localparam int REQ_CYCLES = 12;
    localparam int MAX_CYCLES = REQ_CYCLES * N_REQ + 16;   // plus reset and idle

    logic        CLK;
    logic        rst_n;
    logic        valid;
    lsu_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        ready;
    logic [31:0] rdata;
    logic        misaligned;

    logic [7:0]  ref_mem [DEPTH];           // reference byte model
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    string       cur_test;
    lsu_op_e     bad_ops  [8] = '{LH, LHU, SH, SH, LW, SW, SW, SW};
    logic [1:0]  bad_offs [8] = '{2'd1, 2'd3, 2'd1, 2'd3, 2'd2, 2'd1, 2'd2, 2'd3};

    data_memory_subsystem #(
        .DEPTH (DEPTH)
    ) data_memory_subsystem_inst (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .valid      (valid),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .ready      (ready),
        .rdata      (rdata),
        .misaligned (misaligned)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    // every completion pulse lasts one cycle and carries the error flag with it
    assert property (@(posedge CLK) disable iff (!rst_n) ready |=> !ready)
        else begin
            $display("test %s: ready stayed high for more than one cycle", cur_test);
            note_error();
        end
    assert property (@(posedge CLK) disable iff (!rst_n) misaligned |-> ready)
        else begin
            $display("test %s: misaligned raised without ready", cur_test);
            note_error();
        end

    function automatic logic [7:0] model_byte(logic [31:0] a);
        return ref_mem[a[AW-1:0]];          // wraps modulo DEPTH
    endfunction

    task automatic put_byte(input logic [31:0] a, input logic [7:0] v);
        ref_mem[a[AW-1:0]] = v;
    endtask

    function automatic logic is_store(lsu_op_e o);
        return (o == SB) || (o == SH) || (o == SW);
    endfunction

    function automatic logic is_misaligned(lsu_op_e o, logic [31:0] a);
        case (o)
            LH, LHU, SH: return a[0];
            LW, SW:      return a[1:0] != 2'd0;
            default:     return 1'b0;
        endcase
    endfunction

    // big-endian: byte at offset k lands in bits 31-8k down to 24-8k
    function automatic logic [31:0] expect_load(lsu_op_e o, logic [31:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = model_byte(a);
        h = {model_byte(a), model_byte(a + 32'd1)};
        case (o)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'd0, h};
            default: return {model_byte(a), model_byte(a + 32'd1),
                             model_byte(a + 32'd2), model_byte(a + 32'd3)};
        endcase
    endfunction

    task automatic update_model(input lsu_op_e o, input logic [31:0] a, input logic [31:0] d);
        case (o)
            SB: put_byte(a, d[7:0]);
            SH: begin
                put_byte(a, d[15:8]);
                put_byte(a + 32'd1, d[7:0]);
            end
            SW: begin
                put_byte(a, d[31:24]);
                put_byte(a + 32'd1, d[23:16]);
                put_byte(a + 32'd2, d[15:8]);
                put_byte(a + 32'd3, d[7:0]);
            end
            default: ;
        endcase
    endtask

    // called on a rising edge, returns on the edge that sees ready
    task automatic issue(input lsu_op_e o, input logic [31:0] a, input logic [31:0] d,
                         output logic [31:0] got, output logic got_mis);
        int waited;
        valid  <= 1'b1;
        op     <= o;
        addr   <= a;
        wdata  <= d;
        waited = 0;
        do begin
            @(posedge CLK);
            waited++;
        end while (!ready && waited < REQ_CYCLES);
        assert (ready) else begin
            $display("test %s: no ready within %0d cycles for %s at %h",
                     cur_test, REQ_CYCLES, o.name(), a);
            note_error();
        end
        got     = rdata;
        got_mis = misaligned;
    endtask

    task automatic run_op(input lsu_op_e o, input logic [31:0] a, input logic [31:0] d);
        logic [31:0] got;
        logic        got_mis;
        logic        exp_mis;
        logic [31:0] exp;
        exp_mis = is_misaligned(o, a);
        exp     = expect_load(o, a);
        issue(o, a, d, got, got_mis);
        assert (got_mis == exp_mis) else begin
            $display("Mismatch in %s: misaligned for %s at %h expected %0d actual %0d",
                     cur_test, o.name(), a, exp_mis, got_mis);
            note_error();
        end
        if (!exp_mis && !is_store(o)) begin
            assert (got == exp) else begin
                $display("Mismatch in %s: %s at %h expected %h actual %h",
                         cur_test, o.name(), a, exp, got);
                note_error();
            end
        end
        if (!exp_mis && is_store(o)) begin
            update_model(o, a, d);
        end
    endtask

    function automatic logic [31:0] rand_byte_addr();
        return WIN_BASE + ($urandom % (WIN_WORDS * 4)) + DEPTH * ($urandom % 8);
    endfunction

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", cur_test, test_errs);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int unsigned seed_word;
        logic [31:0] a;
        seed_word    = $urandom(66);
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        valid        = 1'b0;
        op           = LW;
        addr         = 32'd0;
        wdata        = 32'd0;

        begin_test("reset_idle");
        for (int i = 0; i < 12; i++) begin
            @(posedge CLK);
            if (i == 7) begin
                rst_n <= 1'b1;              // release after 8 cycles
            end
            assert (!ready && !misaligned) else begin
                $display("test %s: ready or misaligned high before any request", cur_test);
                note_error();
            end
        end
        end_test();

        begin_test("window_init");
        for (int i = 0; i < WIN_WORDS; i++) begin
            a = WIN_BASE + 4 * i;
            run_op(SW, a, a * 32'h9E37_79B1);   // fill from the full address
        end
        end_test();

        begin_test("word_round_trip");
        for (int i = 0; i < N_ROUND; i++) begin
            a = rand_byte_addr() & 32'hFFFF_FFFC;
            run_op(SW, a, $urandom);
            run_op(LW, a + DEPTH * (1 + $urandom % 4), 32'd0);  // aliased above DEPTH
        end
        end_test();

        begin_test("byte_placement");
        a = WIN_BASE + 4 * 3;
        for (int k = 0; k < 4; k++) begin
            run_op(SB, a + k, $urandom);
        end
        run_op(LW, a, 32'd0);
        end_test();

        begin_test("extension");
        for (int w = 0; w < 2; w++) begin
            a = WIN_BASE + 4 * (5 + w);
            run_op(SW, a, (w == 0) ? 32'h807F_FF01 : 32'h7F80_01FF);
            for (int k = 0; k < 4; k++) begin
                run_op(LB, a + k, 32'd0);
                run_op(LBU, a + k, 32'd0);
            end
            for (int k = 0; k < 4; k += 2) begin
                run_op(LH, a + k, 32'd0);
                run_op(LHU, a + k, 32'd0);
            end
        end
        end_test();

        begin_test("halfword_store");
        a = WIN_BASE + 4 * 8;
        run_op(SH, a, $urandom);
        run_op(LW, a, 32'd0);
        run_op(SH, a + 32'd2, $urandom);
        run_op(LW, a, 32'd0);
        end_test();

        begin_test("misaligned");
        a = WIN_BASE + 4 * 10;
        for (int i = 0; i < 8; i++) begin
            run_op(bad_ops[i], a + 32'(bad_offs[i]), $urandom);
            run_op(LW, a, 32'd0);           // word must be untouched
        end
        end_test();

        begin_test("random_mix");
        for (int i = 0; i < N_MIX; i++) begin
            run_op(lsu_op_e'(3'($urandom_range(7, 0))), rand_byte_addr(), $urandom);
        end
        end_test();

        valid <= 1'b0;
        repeat (2) @(posedge CLK);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/mem_pkg.sv
hdl/byte_ram.sv
hdl/load_store_unit.sv
hdl/memory_interface.sv
hdl/data_memory_subsystem.sv
verification/tb_data_memory_subsystem.sv

//--- Makefile
SHELL      := /bin/bash

VERILATOR  ?= verilator
TOP        ?= tb_data_memory_subsystem
RTL_TOP    ?= data_memory_subsystem
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG   ?= Regression failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
